//--- hdl/cnn_cls_pkg.sv
// Shared widths, bias memory layout and types of the CNN classification back end
package cnn_cls_pkg;

    // Output classes of the final layer
    localparam int NUM_CLASSES = 10;

    // Signed class score and the raw MAC partial sum feeding it
    localparam int SCORE_W = 16;
    localparam int ACCUM_W = 18;

    // Class index or predicted digit
    localparam int DIGIT_W = 4;

    // Bias memory words carry eight 16-bit biases, lane 0 in the top bits
    localparam int BIAS_WORD_W = 128;
    localparam int BIAS_LANES = 8;
    localparam int BIAS_ADDR_W = 4;

    // First bias word of the classifier layer
    localparam int BIAS_BASE_ADDR = 14;

    // One class score, compared as signed
    typedef logic signed [SCORE_W-1:0] score_t;

    // A full frame of class scores, class 0 in the low bits
    typedef score_t [NUM_CLASSES-1:0] score_vec_t;

    // Winning class of an argmax branch together with its score
    typedef struct packed {
        logic [DIGIT_W-1:0] idx;
        score_t             score;
    } class_pick_t;

endpackage

//--- hdl/class_score_bank.sv
// Class score bank that biases MAC partial sums and publishes each complete frame
module class_score_bank
    import cnn_cls_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid_i,
    input  logic [ACCUM_W-1:0]     accum_i,
    input  logic [BIAS_WORD_W-1:0] bias_q_i,
    output logic [BIAS_ADDR_W-1:0] bias_addr_o,
    output score_vec_t             scores_o,
    output logic                   frame_done_o
);

    localparam int LANE_W = $clog2(BIAS_LANES);

    logic [DIGIT_W-1:0]          cls_cnt;
    logic [LANE_W-1:0]           lane;
    logic                        last_cls;
    score_t                      bias;
    score_t                      score;

    // Scores of classes 0..8 while a frame is still arriving
    score_t [NUM_CLASSES-2:0]    work;

    // Bias word and lane follow the class counter
    assign bias_addr_o = BIAS_ADDR_W'(BIAS_BASE_ADDR + (cls_cnt / BIAS_LANES));
    assign lane = LANE_W'(cls_cnt % BIAS_LANES);
    assign bias = bias_q_i[BIAS_WORD_W - 1 - lane * SCORE_W -: SCORE_W];

    // Low 16 bits of the partial sum plus bias, wrapping
    assign score = accum_i[SCORE_W-1:0] + bias;

    assign last_cls = (cls_cnt == DIGIT_W'(NUM_CLASSES - 1));

    // Class counter and frame done strobe
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cls_cnt <= '0;
            frame_done_o <= 1'b0;
        end
        else
        begin
            frame_done_o <= valid_i && last_cls;
            if (valid_i)
            begin
                if (last_cls)
                begin
                    cls_cnt <= '0;
                end
                else
                begin
                    cls_cnt <= cls_cnt + 1'b1;
                end
            end
        end
    end

    // Collect the early classes of the frame
    always_ff @(posedge clk)
    begin
        if (valid_i && !last_cls)
        begin
            work[cls_cnt] <= score;
        end
    end

    // The last class publishes the whole frame at once,
    // so the branches see stable scores until the next frame ends
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scores_o <= '0;
        end
        else if (valid_i && last_cls)
        begin
            scores_o <= {score, work};
        end
    end

    // A frame takes ten beats, so done can never repeat back to back
    frame_done_single_cycle: assert property (
        @(posedge clk) disable iff (rst) frame_done_o |=> !frame_done_o
    ) else $error("frame_done_o held for more than one cycle");

endmodule

//--- hdl/argmax_branch.sv
// Argmax branch that finds the best class of a contiguous range through a registered tree
module argmax_branch
    import cnn_cls_pkg::*;
#(
    parameter int BASE = 0,
    parameter int COUNT = 8,
    parameter int STAGES = 3
)
(
    input  logic        clk,
    input  logic        rst,
    input  score_vec_t  scores_i,
    input  logic        start_i,
    output class_pick_t pick_o,
    output logic        pick_valid_o
);

    // Candidates left after s halvings
    function automatic int level_width(input int s);
        int w;
        w = COUNT;
        for (int k = 0; k < s; k++)
        begin
            w = (w + 1) / 2;
        end
        return w;
    endfunction

    // Upper candidate always holds the higher classes, so it wins ties
    function automatic class_pick_t pick_max(input class_pick_t lo, input class_pick_t hi);
        if ($signed(hi.score) >= $signed(lo.score))
        begin
            return hi;
        end
        return lo;
    endfunction

    class_pick_t leaf [COUNT];

    // Leaves carry the score values with their class index
    for (genvar i = 0; i < COUNT; i++)
    begin : g_leaf
        assign leaf[i] = '{idx: DIGIT_W'(BASE + i), score: scores_i[BASE + i]};
    end

    for (genvar s = 0; s < STAGES; s++)
    begin : g_stage
        localparam int IN_W = level_width(s);
        localparam int OUT_W = level_width(s + 1);

        class_pick_t in_c [IN_W];
        class_pick_t out_q [OUT_W];
        logic        in_v;
        logic        out_v;

        if (s == 0)
        begin : g_src_leaf
            assign in_c = leaf;
            assign in_v = start_i;
        end
        else
        begin : g_src_prev
            assign in_c = g_stage[s - 1].out_q;
            assign in_v = g_stage[s - 1].out_v;
        end

        // Pairs are compared, an odd candidate and a finished tree just move on
        for (genvar j = 0; j < OUT_W; j++)
        begin : g_node
            if (2 * j + 1 < IN_W)
            begin : g_pair
                always_ff @(posedge clk)
                begin
                    out_q[j] <= pick_max(in_c[2 * j], in_c[2 * j + 1]);
                end
            end
            else
            begin : g_pass
                always_ff @(posedge clk)
                begin
                    out_q[j] <= in_c[2 * j];
                end
            end
        end

        always_ff @(posedge clk or posedge rst)
        begin
            if (rst)
            begin
                out_v <= 1'b0;
            end
            else
            begin
                out_v <= in_v;
            end
        end
    end

    assign pick_o = g_stage[STAGES - 1].out_q[0];
    assign pick_valid_o = g_stage[STAGES - 1].out_v;

endmodule

//--- hdl/argmax_merge.sv
// Argmax merge that picks the better of two branch winners as the predicted digit
module argmax_merge
    import cnn_cls_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  class_pick_t        pick_a_i,
    input  class_pick_t        pick_b_i,
    input  logic               valid_i,
    output logic [DIGIT_W-1:0] digit_o,
    output logic               digit_valid_o
);

    logic [DIGIT_W-1:0] winner;

    // Branch B covers the higher classes and takes ties
    assign winner = ($signed(pick_b_i.score) >= $signed(pick_a_i.score)) ? pick_b_i.idx
                                                                          : pick_a_i.idx;

    always_ff @(posedge clk)
    begin
        if (valid_i)
        begin
            digit_o <= winner;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit_valid_o <= 1'b0;
        end
        else
        begin
            digit_valid_o <= valid_i;
        end
    end

    // Indices come from the branch parameters, never from data
    digit_in_range: assert property (
        @(posedge clk) disable iff (rst) digit_valid_o |-> (digit_o < NUM_CLASSES)
    ) else $error("predicted digit %0d out of range", digit_o);

endmodule

//--- hdl/digit_fifo.sv
// Digit FIFO with first-word-fall-through output that drops writes when full
module digit_fifo
    import cnn_cls_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_en_i,
    input  logic [DIGIT_W-1:0] din_i,
    input  logic               rd_en_i,
    output logic [DIGIT_W-1:0] dout_o,
    output logic               empty_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DIGIT_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               push;
    logic               pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full = (count == CNT_W'(FIFO_DEPTH));
    assign empty_o = (count == '0);
    assign push = wr_en_i && !full;
    assign pop = rd_en_i && !empty_o;

    // Head entry is visible without a read
    assign dout_o = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    fifo_no_overflow: assert property (
        @(posedge clk) disable iff (rst) count <= CNT_W'(FIFO_DEPTH)
    ) else $error("FIFO occupancy %0d above depth", count);

endmodule

//--- hdl/cnn_classifier_top.sv
// CNN classifier back end joining score bank, split argmax, merge and result FIFO
module cnn_classifier_top
    import cnn_cls_pkg::*;
#(
    parameter int FIFO_DEPTH = 4,
    parameter int ARGMAX_STAGES = 3
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid_i,
    input  logic [ACCUM_W-1:0]     accum_i,
    input  logic [BIAS_WORD_W-1:0] bias_q_i,
    output logic [BIAS_ADDR_W-1:0] bias_addr_o,
    output logic [DIGIT_W-1:0]     digit_o,
    output logic                   digit_valid_o,
    input  logic                   fifo_rd_en_i,
    output logic [DIGIT_W-1:0]     fifo_dout_o,
    output logic                   fifo_empty_o
);

    // Classes below SPLIT go to the low branch
    localparam int SPLIT = 8;

    score_vec_t  scores;
    logic        frame_done;
    class_pick_t pick_lo;
    class_pick_t pick_hi;
    logic        pick_valid_lo;
    logic        pick_valid_hi;

    class_score_bank u_bank (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (valid_i),
        .accum_i      (accum_i),
        .bias_q_i     (bias_q_i),
        .bias_addr_o  (bias_addr_o),
        .scores_o     (scores),
        .frame_done_o (frame_done)
    );

    argmax_branch #(
        .BASE   (0),
        .COUNT  (SPLIT),
        .STAGES (ARGMAX_STAGES)
    ) branch_lo (
        .clk          (clk),
        .rst          (rst),
        .scores_i     (scores),
        .start_i      (frame_done),
        .pick_o       (pick_lo),
        .pick_valid_o (pick_valid_lo)
    );

    argmax_branch #(
        .BASE   (SPLIT),
        .COUNT  (NUM_CLASSES - SPLIT),
        .STAGES (ARGMAX_STAGES)
    ) branch_hi (
        .clk          (clk),
        .rst          (rst),
        .scores_i     (scores),
        .start_i      (frame_done),
        .pick_o       (pick_hi),
        .pick_valid_o (pick_valid_hi)
    );

    argmax_merge u_merge (
        .clk           (clk),
        .rst           (rst),
        .pick_a_i      (pick_lo),
        .pick_b_i      (pick_hi),
        .valid_i       (pick_valid_lo),
        .digit_o       (digit_o),
        .digit_valid_o (digit_valid_o)
    );

    digit_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en_i (digit_valid_o),
        .din_i   (digit_o),
        .rd_en_i (fifo_rd_en_i),
        .dout_o  (fifo_dout_o),
        .empty_o (fifo_empty_o)
    );

    // Merge trusts the low branch valid for both winners
    branch_valids_aligned: assert property (
        @(posedge clk) disable iff (rst) pick_valid_lo == pick_valid_hi
    ) else $error("argmax branch valids out of step");

endmodule

//--- tests/classifier_checker.sv
// Scoreboard that predicts each digit and the FIFO contents and compares the DUT outputs
module classifier_checker
    import cnn_cls_pkg::*;
#(
    parameter int FIFO_DEPTH = 4,
    parameter int LATENCY = 5
)
(
    input logic                   clk,
    input logic                   rst,
    input logic                   valid_i,
    input logic [ACCUM_W-1:0]     accum_i,
    input logic [BIAS_WORD_W-1:0] bias_q_i,
    input logic [BIAS_ADDR_W-1:0] bias_addr_o,
    input logic [DIGIT_W-1:0]     digit_o,
    input logic                   digit_valid_o,
    input logic                   fifo_rd_en_i,
    input logic [DIGIT_W-1:0]     fifo_dout_o,
    input logic                   fifo_empty_o
);

    int         cycle = 0;
    int         cls = 0;
    int         passes = 0;
    int         errors = 0;
    int         mark_passes = 0;
    int         mark_errors = 0;
    int         pending = 0;
    bit         was_full;
    score_vec_t frame;
    int         digit_q[$];
    int         due_q[$];
    int         fifo_q[$];

    // Lane 0 of a bias word sits in the top 16 bits
    function automatic score_t biased_score(input logic [ACCUM_W-1:0] accum,
                                            input logic [BIAS_WORD_W-1:0] word,
                                            input int c);
        score_t bias;
        bias = score_t'(word >> ((BIAS_LANES - 1 - c % BIAS_LANES) * SCORE_W));
        return score_t'(accum) + bias;
    endfunction

    // Highest score wins and the later class takes a tie
    function automatic int ref_digit(input score_vec_t s);
        int best;
        best = 0;
        for (int c = 1; c < NUM_CLASSES; c++)
            if ($signed(s[c]) >= $signed(s[best]))
                best = c;
        return best;
    endfunction

    task automatic check_value(input string what, input int got, input int exp);
        if (got === exp)
            passes++;
        else
        begin
            errors++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        $display("Test %s done: %0d checks passed, %0d failed", name,
                 passes - mark_passes, errors - mark_errors);
        mark_passes = passes;
        mark_errors = errors;
    endtask

    task automatic final_report();
        $display("Totals: %0d checks passed, %0d checks failed", passes, errors);
    endtask

    always @(posedge clk)
    begin
        if (!rst)
        begin
            cycle++;
            // Each predicted digit is due a fixed number of edges after its last beat
            if (digit_valid_o)
            begin
                if (digit_q.size() == 0)
                    report_error("digit_valid_o pulsed although no frame was completed");
                else
                begin
                    check_value("digit_o", digit_o, digit_q.pop_front());
                    check_value("digit_valid_o cycle", cycle, due_q.pop_front());
                end
            end
            else if (due_q.size() != 0 && due_q[0] <= cycle)
            begin
                report_error("expected digit did not appear on time");
                digit_q.delete(0);
                due_q.delete(0);
            end
            // The FIFO model judges full before this edge's pop
            check_value("fifo_empty_o", fifo_empty_o, fifo_q.size() == 0);
            was_full = (fifo_q.size() == FIFO_DEPTH);
            if (fifo_rd_en_i && fifo_q.size() != 0)
                check_value("fifo_dout_o", fifo_dout_o, fifo_q.pop_front());
            if (digit_valid_o && !was_full)
                fifo_q.push_back(digit_o);
            // Accepted beats build the reference frame
            if (valid_i)
            begin
                check_value("bias_addr_o", bias_addr_o, BIAS_BASE_ADDR + cls / BIAS_LANES);
                frame[cls] = biased_score(accum_i, bias_q_i, cls);
                if (cls == NUM_CLASSES - 1)
                begin
                    digit_q.push_back(ref_digit(frame));
                    due_q.push_back(cycle + LATENCY);
                    cls = 0;
                end
                else
                    cls++;
            end
            pending = digit_q.size();
        end
    end

endmodule

//--- tests/cnn_classifier_tb.sv
// Testbench for the CNN classifier back end driving frames against a random bias memory
module cnn_classifier_tb
    import cnn_cls_pkg::*;
();

    localparam int PERIOD = 4;
    localparam int FIFO_DEPTH = 4;
    localparam int STAGES = 3;
    localparam int MAX_GAP = 3;
    localparam int RAND_FRAMES = 12;
    localparam int TIE_FRAMES = 5;
    localparam int B2B_FRAMES = 4;
    localparam int FULL_FRAMES = 6;
    localparam int NUM_TESTS = 5;
    localparam int SETTLE_CYCLES = 20;
    localparam int TOTAL_BEATS =
        (1 + RAND_FRAMES + TIE_FRAMES + B2B_FRAMES + FULL_FRAMES) * NUM_CLASSES;
    // Every beat may be followed by the longest gap, and each test drains at its end
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * (1 + MAX_GAP) + NUM_TESTS * SETTLE_CYCLES + 50;

    logic                   clk;
    logic                   rst;
    logic                   valid_i;
    logic [ACCUM_W-1:0]     accum_i;
    logic [BIAS_WORD_W-1:0] bias_q_i;
    logic [BIAS_ADDR_W-1:0] bias_addr_o;
    logic [DIGIT_W-1:0]     digit_o;
    logic                   digit_valid_o;
    logic                   fifo_rd_en_i;
    logic [DIGIT_W-1:0]     fifo_dout_o;
    logic                   fifo_empty_o;
    logic [BIAS_WORD_W-1:0] bias_mem [16];
    int                     seed;

    // Bias memory answers in the same cycle
    assign bias_q_i = bias_mem[bias_addr_o];

    cnn_classifier_top #(
        .FIFO_DEPTH    (FIFO_DEPTH),
        .ARGMAX_STAGES (STAGES)
    ) dut (
        .clk           (clk),
        .rst           (rst),
        .valid_i       (valid_i),
        .accum_i       (accum_i),
        .bias_q_i      (bias_q_i),
        .bias_addr_o   (bias_addr_o),
        .digit_o       (digit_o),
        .digit_valid_o (digit_valid_o),
        .fifo_rd_en_i  (fifo_rd_en_i),
        .fifo_dout_o   (fifo_dout_o),
        .fifo_empty_o  (fifo_empty_o)
    );

    classifier_checker #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .LATENCY    (STAGES + 2)
    ) chk (
        .clk           (clk),
        .rst           (rst),
        .valid_i       (valid_i),
        .accum_i       (accum_i),
        .bias_q_i      (bias_q_i),
        .bias_addr_o   (bias_addr_o),
        .digit_o       (digit_o),
        .digit_valid_o (digit_valid_o),
        .fifo_rd_en_i  (fifo_rd_en_i),
        .fifo_dout_o   (fifo_dout_o),
        .fifo_empty_o  (fifo_empty_o)
    );

    function automatic logic [ACCUM_W-1:0] random_accum();
        return ACCUM_W'($urandom);
    endfunction

    // Partial sum that lands exactly on the wanted score for class c
    function automatic logic [ACCUM_W-1:0] accum_for(input score_t target, input int c);
        logic [BIAS_WORD_W-1:0] word;
        score_t                 bias;
        word = bias_mem[BIAS_BASE_ADDR + c / BIAS_LANES];
        bias = score_t'(word >> ((BIAS_LANES - 1 - c % BIAS_LANES) * SCORE_W));
        return {2'($urandom), score_t'(target - bias)};
    endfunction

    // Two classes share the peak, the rest sit just below it
    function automatic score_vec_t tie_vec(input int a, input int b, input int peak);
        score_vec_t t;
        for (int c = 0; c < NUM_CLASSES; c++)
            t[c] = score_t'(peak - 50 - c);
        t[a] = score_t'(peak);
        t[b] = score_t'(peak);
        return t;
    endfunction

    task automatic drive_beat(input logic [ACCUM_W-1:0] accum, input int gap);
        @(posedge clk);
        valid_i <= 1'b1;
        accum_i <= accum;
        repeat (gap)
        begin
            @(posedge clk);
            valid_i <= 1'b0;
        end
    endtask

    task automatic send_random_frame(input int max_gap);
        for (int c = 0; c < NUM_CLASSES; c++)
            drive_beat(random_accum(), $urandom_range(max_gap, 0));
    endtask

    task automatic send_scores(input score_vec_t t);
        for (int c = 0; c < NUM_CLASSES; c++)
            drive_beat(accum_for(t[c], c), 0);
    endtask

    // Stop the beats and wait until every expected digit has come out
    task automatic settle();
        @(posedge clk);
        valid_i <= 1'b0;
        @(negedge clk);
        while (chk.pending != 0)
            @(negedge clk);
        repeat (3) @(negedge clk);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        seed = 32'h8474a58f;
        void'($urandom(seed));
        for (int w = 0; w < 16; w++)
            for (int k = 0; k < BIAS_WORD_W / 32; k++)
                bias_mem[w][k * 32 +: 32] = $urandom;
        rst = 1'b1;
        valid_i = 1'b0;
        accum_i = '0;
        fifo_rd_en_i = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Idle outputs after reset, then a slow frame with a pause before its last beat
        @(negedge clk);
        chk.check_value("digit_valid_o after reset", digit_valid_o, 0);
        chk.check_value("fifo_empty_o after reset", fifo_empty_o, 1);
        for (int c = 0; c < NUM_CLASSES - 1; c++)
            drive_beat(random_accum(), 2);
        repeat (10) @(posedge clk);
        drive_beat(random_accum(), 0);
        settle();
        chk.end_test("reset_and_first_frame");

        repeat (RAND_FRAMES) send_random_frame(MAX_GAP);
        settle();
        chk.end_test("random_frames");

        send_scores(tie_vec(2, 5, 100));
        send_scores(tie_vec(3, 9, -7));
        send_scores(tie_vec(8, 9, 300));
        send_scores(tie_vec(0, 8, -30000));
        send_scores(tie_vec(1, 7, 32767));
        settle();
        chk.end_test("tie_frames");

        repeat (B2B_FRAMES) send_random_frame(0);
        settle();
        chk.end_test("back_to_back_frames");

        // FIFO keeps only its depth while nobody reads
        @(posedge clk);
        fifo_rd_en_i <= 1'b0;
        repeat (FULL_FRAMES) send_random_frame(0);
        settle();
        @(posedge clk);
        fifo_rd_en_i <= 1'b1;
        @(negedge clk);
        while (!fifo_empty_o)
            @(negedge clk);
        repeat (2) @(negedge clk);
        chk.end_test("fifo_full_and_drain");

        chk.final_report();
        if (chk.errors == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
hdl/cnn_cls_pkg.sv
hdl/class_score_bank.sv
hdl/argmax_branch.sv
hdl/argmax_merge.sv
hdl/digit_fifo.sv
hdl/cnn_classifier_top.sv
tests/classifier_checker.sv
tests/cnn_classifier_tb.sv

//--- Bender.yml
package:
  name: cnn_classifier

sources:
  - files:
      - hdl/cnn_cls_pkg.sv
      - hdl/class_score_bank.sv
      - hdl/argmax_branch.sv
      - hdl/argmax_merge.sv
      - hdl/digit_fifo.sv
      - hdl/cnn_classifier_top.sv
  - target: test
    files:
      - tests/classifier_checker.sv
      - tests/cnn_classifier_tb.sv
